// File: verification/debug_display_testdata.txt
# name op addr wdata wstrb resp expected(read data; leds after a write; unused for status) frame
# frame: 16 hex digits, top digit first; all x means no frame check
rd_value_rst read 0 00000000 0 0 00000000 xxxxxxxxxxxxxxxx
rd_dots_rst read 4 00000000 0 0 00000000 xxxxxxxxxxxxxxxx
rd_leds_rst read 8 00000000 0 0 00000000 xxxxxxxxxxxxxxxx
rd_status_rst read c 00000000 0 0 00000000 xxxxxxxxxxxxxxxx
wr_value_a write 0 0123abcd f 0 00000000 c0f9a4b08883c6a1
rd_value_a read 0 00000000 0 0 0123abcd xxxxxxxxxxxxxxxx
wr_value_b write 0 deadbeef f 0 00000000 a18688a18386868e
wr_value_part write 0 12345678 3 0 00000000 a18688a19282f880
rd_value_part read 0 00000000 0 0 dead5678 xxxxxxxxxxxxxxxx
wr_dots write 4 00000081 1 0 00000000 218688a19282f800
rd_dots read 4 00000000 0 0 00000081 xxxxxxxxxxxxxxxx
status_after_frames status c 00000000 0 0 00000000 xxxxxxxxxxxxxxxx
wr_leds write 8 0000a5c3 1 0 000000c3 xxxxxxxxxxxxxxxx
wr_leds_upper write 8 000000ff e 0 000000c3 xxxxxxxxxxxxxxxx
rd_leds read 8 00000000 0 0 000000c3 xxxxxxxxxxxxxxxx
wr_status write c 0000ffff f 2 000000c3 xxxxxxxxxxxxxxxx
status_after_err status c 00000000 0 0 00000000 xxxxxxxxxxxxxxxx
rd_unaligned read 2 00000000 0 3 00000000 xxxxxxxxxxxxxxxx
wr_unaligned write 6 ffffffff f 3 000000c3 xxxxxxxxxxxxxxxx

// File: debug_display_top.f
verilog/display_pkg.sv
verilog/axil_pkg.sv
verilog/debug_regs.sv
verilog/segment_frame_encoder.sv
verilog/segment_serializer.sv
verilog/debug_display_top.sv
verification/debug_display_tb.sv

// File: Makefile
# Verilator flow; run from the project root so the test data path resolves
TB_TOP = debug_display_tb
RTL_TOP = debug_display_top

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(RTL_TOP) -f debug_display_top.f

# a $fatal in the testbench gives a nonzero exit status
sim:
	verilator --binary --timing -j 0 --top-module $(TB_TOP) -Mdir obj_dir \
		-f debug_display_top.f
	./obj_dir/V$(TB_TOP)

clean:
	rm -rf obj_dir

// File: verification/debug_display_tb.sv
// needs verification/debug_display_testdata.txt relative to the working directory; run from the project root
`timescale 1ns/1ps

module debug_display_tb;
	import axil_pkg::*;
	import display_pkg::*;

	logic clk200m;
	logic reset;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	led_pattern_t leds;
	seg_serial_t seg_serial;

	// serial capture state
	logic prev_seg_clk;
	logic prev_seg_latch;
	seg_frame_t shift_in;
	int bits_in;
	seg_frame_t last_frame;
	// latch rises seen, and latch falls (one per frame_done)
	int frames_seen;
	int frames_done;

	int cycle_count = 0;
	int cycle_limit = 0;
	string test_lines[$];

	debug_display_top debug_display_top_inst (
		.clk200m (clk200m),
		.reset (reset),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.leds (leds),
		.seg_serial (seg_serial)
	);

	initial clk200m = 1'b0;
	always #10 clk200m = ~clk200m;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_resp(input string name, input axil_resp_t expected,
			input axil_resp_t actual);
		if (actual !== expected)
			stop_run($sformatf("Mismatch %s: resp expected %0h actual %0h", name,
				expected, actual));
	endtask

	task automatic check_data(input string name, input axil_data_t expected,
			input axil_data_t actual);
		if (actual !== expected)
			stop_run($sformatf("Mismatch %s: data expected %08h actual %08h", name,
				expected, actual));
	endtask

	task automatic check_frame(input string name, input seg_frame_t expected,
			input seg_frame_t actual);
		if (actual !== expected)
			stop_run($sformatf("Mismatch %s: frame expected %016h actual %016h", name,
				expected, actual));
	endtask

	task automatic check_leds(input string name, input led_pattern_t expected,
			input led_pattern_t actual);
		if (actual !== expected)
			stop_run($sformatf("Mismatch %s: leds expected %02h actual %02h", name,
				expected, actual));
	endtask

	task automatic check_serial(input string name, input seg_serial_t expected,
			input seg_serial_t actual);
		if (actual !== expected)
			stop_run($sformatf("Mismatch %s: serial pins expected %04b actual %04b", name,
				expected, actual));
	endtask

	// hung DUT guard
	always @(posedge clk200m) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
			stop_run("timeout: the run hung waiting for a bus response or a display frame");
	end

	// shift in on each seg_clk rise, frame complete at latch rise
	always @(posedge clk200m) begin
		prev_seg_clk <= seg_serial.seg_clk;
		prev_seg_latch <= seg_serial.seg_latch;
		if (reset) begin
			bits_in <= 0;
			frames_seen <= 0;
			frames_done <= 0;
		end else begin
			if (seg_serial.seg_clk && !prev_seg_clk) begin
				shift_in <= {shift_in[FRAME_BITS-2:0], seg_serial.seg_data};
				bits_in <= bits_in + 1;
			end
			if (seg_serial.seg_latch && !prev_seg_latch) begin
				if (bits_in != FRAME_BITS)
					stop_run($sformatf("frame latched after %0d bits instead of 64", bits_in));
				last_frame <= shift_in;
				frames_seen <= frames_seen + 1;
				bits_in <= 0;
			end
			// frame_done is high now, counter steps on this edge
			if (!seg_serial.seg_latch && prev_seg_latch)
				frames_done <= frames_done + 1;
		end
	end

	task automatic bus_write(input axil_addr_t addr, input axil_data_t data,
			input axil_strb_t strb, output axil_resp_t resp);
		@(posedge clk200m);
		axil_req.awaddr <= addr;
		axil_req.awvalid <= 1'b1;
		axil_req.wdata <= data;
		axil_req.wstrb <= strb;
		axil_req.wvalid <= 1'b1;
		axil_req.bready <= 1'b1;
		// address and data accepted together
		do @(posedge clk200m); while (!axil_rsp.awready);
		if (!axil_rsp.wready)
			stop_run("write data was not accepted together with the write address");
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid <= 1'b0;
		do @(posedge clk200m); while (!axil_rsp.bvalid);
		resp = axil_rsp.bresp;
		axil_req.bready <= 1'b0;
	endtask

	task automatic bus_read(input axil_addr_t addr, output axil_data_t data,
			output axil_resp_t resp, output int frames_at_accept);
		@(posedge clk200m);
		axil_req.araddr <= addr;
		axil_req.arvalid <= 1'b1;
		axil_req.rready <= 1'b1;
		do @(posedge clk200m); while (!axil_rsp.arready);
		// status value is taken on this edge
		frames_at_accept = frames_done;
		axil_req.arvalid <= 1'b0;
		do @(posedge clk200m); while (!axil_rsp.rvalid);
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		axil_req.rready <= 1'b0;
	endtask

	initial begin
		int fd;
		int code;
		int n;
		int start_frames;
		int frames_now;
		int frames_prev;
		string line;
		string name;
		string op;
		string frame_txt;
		axil_addr_t addr;
		axil_data_t data;
		axil_strb_t strb;
		axil_resp_t exp_resp;
		axil_resp_t resp;
		axil_data_t exp_val;
		axil_data_t rdata;
		seg_frame_t exp_frame;
		frame_count_t status_prev;
		frame_count_t exp_count;
		seg_serial_t idle_pins;

		axil_req <= '0;
		reset <= 1'b1;
		frames_prev = 0;
		status_prev = '0;

		fd = $fopen("verification/debug_display_testdata.txt", "r");
		if (fd == 0)
			stop_run("cannot open the test data file");
		// skip comments and blank lines
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code > 1 && line.getc(0) != "#")
				test_lines.push_back(line);
		end
		$fclose(fd);
		// worst case three refresh periods per test line
		cycle_limit = (test_lines.size() + 2) * 3 * REFRESH_CYCLES;

		repeat (16) @(posedge clk200m);
		check_serial("in_reset", '0, seg_serial);
		reset <= 1'b0;
		repeat (2) @(posedge clk200m);
		idle_pins = '0;
		idle_pins.seg_clear_n = 1'b1;
		check_serial("after_reset", idle_pins, seg_serial);
		check_leds("after_reset", '0, leds);
		if (axil_rsp.awready || axil_rsp.wready || axil_rsp.bvalid || axil_rsp.arready
				|| axil_rsp.rvalid)
			stop_run("bus ready or valid outputs active after reset");

		foreach (test_lines[i]) begin
			n = $sscanf(test_lines[i], "%s %s %h %h %h %h %h %s", name, op, addr, data,
				strb, exp_resp, exp_val, frame_txt);
			if (n != 8)
				stop_run($sformatf("malformed test line: %s", test_lines[i]));
			if (op == "write") begin
				bus_write(addr, data, strb, resp);
				check_resp(name, exp_resp, resp);
				check_leds(name, exp_val[7:0], leds);
				if (frame_txt != "xxxxxxxxxxxxxxxx") begin
					n = $sscanf(frame_txt, "%h", exp_frame);
					// frame in flight may predate the write
					start_frames = frames_seen;
					while (frames_seen < start_frames + 2)
						@(posedge clk200m);
					check_frame(name, exp_frame, last_frame);
				end
			end else if (op == "read") begin
				bus_read(addr, rdata, resp, frames_now);
				check_resp(name, exp_resp, resp);
				check_data(name, exp_val, rdata);
			end else if (op == "status") begin
				bus_read(addr, rdata, resp, frames_now);
				check_resp(name, exp_resp, resp);
				// counter moves by the frames seen since the last status read
				exp_count = status_prev + frame_count_t'(frames_now - frames_prev);
				check_data(name, {16'b0, exp_count}, rdata);
				status_prev = exp_count;
				frames_prev = frames_now;
			end else begin
				stop_run($sformatf("unknown operation %s in test %s", op, name));
			end
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: verilog/debug_display_top.sv
// debug display top; single clock domain, the serial display refreshes every REFRESH_CYCLES cycles
`timescale 1ns/1ps

module debug_display_top (
	input logic clk200m,
	input logic reset,
	input axil_pkg::axil_req_t axil_req,
	output axil_pkg::axil_rsp_t axil_rsp,
	output display_pkg::led_pattern_t leds,
	output display_pkg::seg_serial_t seg_serial
);
	import display_pkg::*;

	// register block to encoder
	display_cfg_t display_cfg;
	// encoder to serializer
	seg_frame_t frame;
	// serializer back to the status counter
	logic frame_done;

	// bus side, value, dots, leds and frame counter
	debug_regs debug_regs_inst (
		.clk200m (clk200m),
		.reset (reset),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.frame_done (frame_done),
		.display_cfg (display_cfg),
		.leds (leds)
	);

	// eight digits to one registered frame
	segment_frame_encoder segment_frame_encoder_inst (
		.clk200m (clk200m),
		.reset (reset),
		.display_cfg (display_cfg),
		.frame (frame)
	);

	// frame out to the board shift register
	segment_serializer segment_serializer_inst (
		.clk200m (clk200m),
		.reset (reset),
		.frame (frame),
		.seg_serial (seg_serial),
		.frame_done (frame_done)
	);

endmodule

// File: verilog/segment_serializer.sv
// MSB-first serial frame output on clk200m; seg_clk is a registered pin, not a clock
`timescale 1ns/1ps

module segment_serializer (
	input logic clk200m,
	input logic reset,
	input display_pkg::seg_frame_t frame,
	output display_pkg::seg_serial_t seg_serial,
	output logic frame_done
);
	import display_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_SHIFT, S_LATCH} ser_state_t;
	typedef logic [$clog2(REFRESH_CYCLES)-1:0] refresh_count_t;
	typedef logic [$clog2(BIT_CYCLES)-1:0] bit_phase_t;
	typedef logic [$clog2(FRAME_BITS)-1:0] bit_index_t;

	ser_state_t state;
	refresh_count_t refresh_cnt;
	logic refresh_start;
	bit_phase_t phase;
	bit_phase_t phase_next;
	logic phase_last;
	bit_index_t bit_cnt;
	seg_frame_t shift_reg;
	logic seg_clk_q;
	logic seg_clear_n_q;
	logic seg_data_q;
	logic seg_latch_q;

	// free running, never stalled by the bus
	always_ff @(posedge clk200m) begin
		if (reset)
			refresh_cnt <= '0;
		else if (refresh_start)
			refresh_cnt <= '0;
		else
			refresh_cnt <= refresh_cnt + 1'b1;
	end

	assign refresh_start = (refresh_cnt == refresh_count_t'(REFRESH_CYCLES - 1));

	// bit phase, low half then high half of seg_clk
	assign phase_next = phase_last ? '0 : phase + 1'b1;
	assign phase_last = (phase == bit_phase_t'(BIT_CYCLES - 1));

	always_ff @(posedge clk200m) begin
		if (reset) begin
			state <= S_IDLE;
			phase <= '0;
			bit_cnt <= '0;
			seg_clk_q <= 1'b0;
			seg_clear_n_q <= 1'b0;
			seg_data_q <= 1'b0;
			seg_latch_q <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			// clear only held through reset
			seg_clear_n_q <= 1'b1;
			frame_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (refresh_start) begin
						// first bit out while clk is low
						state <= S_SHIFT;
						phase <= '0;
						bit_cnt <= '0;
						seg_clk_q <= 1'b0;
						seg_data_q <= frame[FRAME_BITS-1];
					end
				end
				S_SHIFT: begin
					phase <= phase_next;
					seg_clk_q <= (phase_next >= bit_phase_t'(BIT_CYCLES / 2));
					if (phase_last) begin
						if (bit_cnt == bit_index_t'(FRAME_BITS - 1)) begin
							state <= S_LATCH;
							seg_data_q <= 1'b0;
							seg_latch_q <= 1'b1;
						end else begin
							// next bit changes on the falling edge
							bit_cnt <= bit_cnt + 1'b1;
							seg_data_q <= shift_reg[FRAME_BITS-1];
						end
					end
				end
				S_LATCH: begin
					// latch high for one bit time
					phase <= phase_next;
					if (phase_last) begin
						state <= S_IDLE;
						seg_latch_q <= 1'b0;
						frame_done <= 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// snapshot at refresh start without the bit already on the pin, shifted once per bit
	always_ff @(posedge clk200m) begin
		if (state == S_IDLE && refresh_start)
			shift_reg <= {frame[FRAME_BITS-2:0], 1'b0};
		else if (state == S_SHIFT && phase_last)
			shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b0};
	end

	assign seg_serial.seg_clk = seg_clk_q;
	assign seg_serial.seg_clear_n = seg_clear_n_q;
	assign seg_serial.seg_data = seg_data_q;
	assign seg_serial.seg_latch = seg_latch_q;

endmodule

// File: verilog/segment_frame_encoder.sv
// hex to seven-segment frame, one cycle latency; blank frame while in reset
`timescale 1ns/1ps

module segment_frame_encoder (
	input logic clk200m,
	input logic reset,
	input display_pkg::display_cfg_t display_cfg,
	output display_pkg::seg_frame_t frame
);
	import display_pkg::*;

	seg_frame_t next_frame;

	// table is active high, inverted once at the end
	function automatic seg_code_t encode_digit(input hex_digit_t digit, input logic dot);
		logic [6:0] lit;
		case (digit)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7F;
			4'h9: lit = 7'h6F;
			// lower case b and d, others upper
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;
			4'hC: lit = 7'h39;
			4'hD: lit = 7'h5E;
			4'hE: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~{dot, lit};
	endfunction

	// digit i goes to byte i
	always_comb begin
		for (int i = 0; i < DIGIT_COUNT; i++) begin
			next_frame[i*8 +: 8] = encode_digit(display_cfg.value[i*4 +: 4],
				display_cfg.dots[i]);
		end
	end

	always_ff @(posedge clk200m) begin
		if (reset)
			// all segments dark
			frame <= '1;
		else
			frame <= next_frame;
	end

endmodule

// File: verilog/debug_regs.sv
// AXI4-Lite slave, one write and one read in flight; master must hold valid until ready
`timescale 1ns/1ps

module debug_regs (
	input logic clk200m,
	input logic reset,
	input axil_pkg::axil_req_t axil_req,
	output axil_pkg::axil_rsp_t axil_rsp,
	input logic frame_done,
	output display_pkg::display_cfg_t display_cfg,
	output display_pkg::led_pattern_t leds
);
	import axil_pkg::*;
	import display_pkg::*;

	typedef enum logic [1:0] {WR_IDLE, WR_ACCEPT, WR_RESP} wr_state_t;
	typedef enum logic [1:0] {RD_IDLE, RD_ACCEPT, RD_RESP} rd_state_t;

	wr_state_t wr_state;
	rd_state_t rd_state;
	display_value_t value_reg;
	dot_mask_t dots_reg;
	led_pattern_t leds_reg;
	frame_count_t frame_count;
	axil_resp_t wr_resp;
	axil_resp_t rd_resp;
	axil_data_t rd_data;
	axil_resp_t bresp_reg;
	axil_resp_t rresp_reg;
	axil_data_t rdata_reg;

	// byte lanes with strobe set take the new data
	function automatic axil_data_t merge_bytes(input axil_data_t old_data,
			input axil_data_t new_data, input axil_strb_t strb);
		axil_data_t merged;
		merged = old_data;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				merged[b*8 +: 8] = new_data[b*8 +: 8];
		end
		return merged;
	endfunction

	// write decode, status is read only
	always_comb begin
		case (axil_req.awaddr)
			REG_VALUE, REG_DOTS, REG_LEDS: wr_resp = RESP_OKAY;
			REG_STATUS: wr_resp = RESP_SLVERR;
			default: wr_resp = RESP_DECERR;
		endcase
	end

	// read decode, narrow registers zero extended
	always_comb begin
		rd_resp = RESP_OKAY;
		case (axil_req.araddr)
			REG_VALUE: rd_data = value_reg;
			REG_DOTS: rd_data = {24'b0, dots_reg};
			REG_LEDS: rd_data = {24'b0, leds_reg};
			REG_STATUS: rd_data = {16'b0, frame_count};
			default: begin
				// unaligned
				rd_data = '0;
				rd_resp = RESP_DECERR;
			end
		endcase
	end

	// write channel, ready pulse one cycle after both valids
	always_ff @(posedge clk200m) begin
		if (reset) begin
			wr_state <= WR_IDLE;
			value_reg <= '0;
			dots_reg <= '0;
			leds_reg <= '0;
		end else begin
			case (wr_state)
				WR_IDLE: begin
					if (axil_req.awvalid && axil_req.wvalid)
						wr_state <= WR_ACCEPT;
				end
				WR_ACCEPT: begin
					// handshake happens here, register update with it
					wr_state <= WR_RESP;
					case (axil_req.awaddr)
						REG_VALUE: value_reg <= merge_bytes(value_reg, axil_req.wdata,
							axil_req.wstrb);
						REG_DOTS: if (axil_req.wstrb[0]) dots_reg <= axil_req.wdata[7:0];
						REG_LEDS: if (axil_req.wstrb[0]) leds_reg <= axil_req.wdata[7:0];
						default: ;
					endcase
				end
				WR_RESP: begin
					if (axil_req.bready)
						wr_state <= WR_IDLE;
				end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	// read channel, same shape as write
	always_ff @(posedge clk200m) begin
		if (reset) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
				RD_IDLE: if (axil_req.arvalid) rd_state <= RD_ACCEPT;
				RD_ACCEPT: rd_state <= RD_RESP;
				RD_RESP: if (axil_req.rready) rd_state <= RD_IDLE;
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	// response payload captured at the handshake
	always_ff @(posedge clk200m) begin
		if (wr_state == WR_ACCEPT)
			bresp_reg <= wr_resp;
		if (rd_state == RD_ACCEPT) begin
			rdata_reg <= rd_data;
			rresp_reg <= rd_resp;
		end
	end

	// frames sent, wraps at 2^16
	always_ff @(posedge clk200m) begin
		if (reset)
			frame_count <= '0;
		else if (frame_done)
			frame_count <= frame_count + 1'b1;
	end

	always_comb begin
		axil_rsp.awready = (wr_state == WR_ACCEPT);
		axil_rsp.wready = (wr_state == WR_ACCEPT);
		axil_rsp.bvalid = (wr_state == WR_RESP);
		axil_rsp.bresp = bresp_reg;
		axil_rsp.arready = (rd_state == RD_ACCEPT);
		axil_rsp.rvalid = (rd_state == RD_RESP);
		axil_rsp.rdata = rdata_reg;
		axil_rsp.rresp = rresp_reg;
	end

	assign display_cfg.value = value_reg;
	assign display_cfg.dots = dots_reg;
	assign leds = leds_reg;

endmodule

// File: verilog/axil_pkg.sv
// AXI4-Lite types for the 16-byte debug register window; no burst or protection signals
package axil_pkg;

	typedef logic [3:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [3:0] axil_strb_t;
	typedef logic [1:0] axil_resp_t;

	localparam axil_resp_t RESP_OKAY = 2'b00;
	localparam axil_resp_t RESP_SLVERR = 2'b10;
	localparam axil_resp_t RESP_DECERR = 2'b11;

	// register map, word aligned
	localparam axil_addr_t REG_VALUE = 4'h0;
	localparam axil_addr_t REG_DOTS = 4'h4;
	localparam axil_addr_t REG_LEDS = 4'h8;
	// read-only frame counter
	localparam axil_addr_t REG_STATUS = 4'hC;

	// master to slave
	typedef struct packed {
		axil_addr_t awaddr;
		logic awvalid;
		axil_data_t wdata;
		axil_strb_t wstrb;
		logic wvalid;
		logic bready;
		axil_addr_t araddr;
		logic arvalid;
		logic rready;
	} axil_req_t;

	// slave to master
	typedef struct packed {
		logic awready;
		logic wready;
		axil_resp_t bresp;
		logic bvalid;
		logic arready;
		axil_data_t rdata;
		axil_resp_t rresp;
		logic rvalid;
	} axil_rsp_t;

endpackage

// File: verilog/display_pkg.sv
// display types and timing; eight-digit active-low serial display, all counts in clk200m cycles
package display_pkg;

	// fixed by the display board
	localparam int DIGIT_COUNT = 8;
	localparam int FRAME_BITS = 64;

	// clk200m cycles per shifted bit, half low and half high
	localparam int BIT_CYCLES = 4;
	// cycles between frame starts, must exceed one frame plus latch
	localparam int REFRESH_CYCLES = 512;

	typedef logic [3:0] hex_digit_t;
	// bit 0 = segment a .. bit 6 = g, bit 7 = decimal point, all active low
	typedef logic [7:0] seg_code_t;
	// most significant digit in the top byte
	typedef logic [FRAME_BITS-1:0] seg_frame_t;
	typedef logic [31:0] display_value_t;
	// bit i lights the dot of digit i
	typedef logic [DIGIT_COUNT-1:0] dot_mask_t;
	typedef logic [7:0] led_pattern_t;
	typedef logic [15:0] frame_count_t;

	// what the register block hands to the encoder
	typedef struct packed {
		display_value_t value;
		dot_mask_t dots;
	} display_cfg_t;

	// board pins of the serial shift register
	typedef struct packed {
		logic seg_clk;
		logic seg_clear_n;
		logic seg_data;
		logic seg_latch;
	} seg_serial_t;

endpackage
